/* rtl/cgra_pkg.sv */
package cgra_pkg;

	// Element codes, compared with the upper half of config_addr
	localparam logic [15:0] CFG_SB  = 16'd7;
	localparam logic [15:0] CFG_CB0 = 16'd6;
	localparam logic [15:0] CFG_CB1 = 16'd5;
	localparam logic [15:0] CFG_CLB = 16'd4;

	// Fabric geometry
	localparam int TRACKS = 4;
	localparam int SIDES  = 4;

	// Configuration field widths
	localparam int SB_SEL_W  = 2;
	localparam int CB_SEL_W  = 3;
	localparam int CLB_OP_W  = 2;
	localparam int TILE_ID_W = 16;

	// Logic block opcodes
	localparam logic [CLB_OP_W-1:0] CLB_AND  = 2'd0;
	localparam logic [CLB_OP_W-1:0] CLB_OR   = 2'd1;
	localparam logic [CLB_OP_W-1:0] CLB_XOR  = 2'd2;
	localparam logic [CLB_OP_W-1:0] CLB_NAND = 2'd3;

	// Switch box select value that routes the logic block output
	localparam logic [SB_SEL_W-1:0] SB_SEL_PE = 2'd3;

	// One configuration word, seen either as a raw word or as switch box selects.
	// Select s*TRACKS+t drives side s, track t.
	typedef union packed {
		logic [31:0] raw;
		logic [TRACKS*SIDES-1:0][SB_SEL_W-1:0] sb_sel;
	} cfg_word_u;

endpackage

/* rtl/switch_box.sv */
`timescale 1ns/100ps

module switch_box (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                config_en,
	input  cgra_pkg::cfg_word_u config_data,
	input  logic [3:0]          in_wire_0,
	input  logic [3:0]          in_wire_1,
	input  logic [3:0]          in_wire_2,
	input  logic [3:0]          in_wire_3,
	input  logic                pe_output,
	output logic [3:0]          out_wire_0,
	output logic [3:0]          out_wire_1,
	output logic [3:0]          out_wire_2,
	output logic [3:0]          out_wire_3
);

	import cgra_pkg::*;

	cfg_word_u sel_q;

	logic [TRACKS-1:0] in_side  [SIDES];
	logic [TRACKS-1:0] out_side [SIDES];

	// Select register, one two-bit field per output track
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q.raw <= '0;
		end else if (config_en) begin
			sel_q.sb_sel <= config_data.sb_sel;
		end
	end

	assign in_side[0] = in_wire_0;
	assign in_side[1] = in_wire_1;
	assign in_side[2] = in_wire_2;
	assign in_side[3] = in_wire_3;

	// Selects 0..2 pick one of the other three sides, counting clockwise
	always_comb begin
		for (int s = 0; s < SIDES; s++) begin
			for (int t = 0; t < TRACKS; t++) begin
				if (sel_q.sb_sel[s*TRACKS+t] == SB_SEL_PE) begin
					out_side[s][t] = pe_output;
				end else begin
					out_side[s][t] = in_side[(s + 1 + sel_q.sb_sel[s*TRACKS+t]) % SIDES][t];
				end
			end
		end
	end

	assign out_wire_0 = out_side[0];
	assign out_wire_1 = out_side[1];
	assign out_wire_2 = out_side[2];
	assign out_wire_3 = out_side[3];

endmodule

/* rtl/connect_box.sv */
`timescale 1ns/100ps

module connect_box (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                config_en,
	input  cgra_pkg::cfg_word_u config_data,
	input  logic [7:0]          tracks,
	output logic                block_out
);

	import cgra_pkg::*;

	logic [CB_SEL_W-1:0] sel_q;

	// Only the low bits of the raw word matter here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data.raw[CB_SEL_W-1:0];
		end
	end

	assign block_out = tracks[sel_q];

endmodule

/* rtl/clb.sv */
`timescale 1ns/100ps

module clb (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                config_en,
	input  cgra_pkg::cfg_word_u config_data,
	input  logic                in0,
	input  logic                in1,
	output logic                out
);

	import cgra_pkg::*;

	logic [CLB_OP_W-1:0] op_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= CLB_AND;
		end else if (config_en) begin
			op_q <= config_data.raw[CLB_OP_W-1:0];
		end
	end

	always_comb begin
		case (op_q)
			CLB_AND:  out = in0 & in1;
			CLB_OR:   out = in0 | in1;
			CLB_XOR:  out = in0 ^ in1;
			CLB_NAND: out = ~(in0 & in1);
			default:  out = 1'bx;
		endcase
	end

	// Opcode register must always hold a legal value once out of reset
	out_known_a: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown({in0, in1}) |-> !$isunknown(out)
	) else $error("clb output unknown with known inputs");

endmodule

/* rtl/pe_tile.sv */
`timescale 1ns/100ps

module pe_tile #(
	parameter logic [cgra_pkg::TILE_ID_W-1:0] TILE_ID = '0
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [31:0]         config_addr,
	input  cgra_pkg::cfg_word_u config_data,
	input  logic [3:0]          in_wire_0,
	input  logic [3:0]          in_wire_1,
	input  logic [3:0]          in_wire_2,
	input  logic [3:0]          in_wire_3,
	output logic [3:0]          out_wire_0,
	output logic [3:0]          out_wire_1,
	output logic [3:0]          out_wire_2,
	output logic [3:0]          out_wire_3
);

	import cgra_pkg::*;

	logic tile_hit;
	logic en_sb;
	logic en_cb0;
	logic en_cb1;
	logic en_clb;

	logic [7:0] cb0_tracks;
	logic [7:0] cb1_tracks;
	logic       op_0;
	logic       op_1;
	logic       pe_output;

	// Lower half picks the tile, upper half the element
	assign tile_hit = (config_addr[TILE_ID_W-1:0] == TILE_ID);

	assign en_sb  = tile_hit && (config_addr[31:16] == CFG_SB);
	assign en_cb0 = tile_hit && (config_addr[31:16] == CFG_CB0);
	assign en_cb1 = tile_hit && (config_addr[31:16] == CFG_CB1);
	assign en_clb = tile_hit && (config_addr[31:16] == CFG_CLB);

	switch_box sb (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_en  (en_sb),
		.config_data(config_data),
		.in_wire_0  (in_wire_0),
		.in_wire_1  (in_wire_1),
		.in_wire_2  (in_wire_2),
		.in_wire_3  (in_wire_3),
		.pe_output  (pe_output),
		.out_wire_0 (out_wire_0),
		.out_wire_1 (out_wire_1),
		.out_wire_2 (out_wire_2),
		.out_wire_3 (out_wire_3)
	);

	// Tracks 0-3 come in on the side, tracks 4-7 go out on it
	assign cb0_tracks = {out_wire_0, in_wire_0};
	assign cb1_tracks = {out_wire_1, in_wire_1};

	connect_box cb0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_en  (en_cb0),
		.config_data(config_data),
		.tracks     (cb0_tracks),
		.block_out  (op_0)
	);

	connect_box cb1 (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_en  (en_cb1),
		.config_data(config_data),
		.tracks     (cb1_tracks),
		.block_out  (op_1)
	);

	clb compute_block (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_en  (en_clb),
		.config_data(config_data),
		.in0        (op_0),
		.in1        (op_1),
		.out        (pe_output)
	);

	// A single address may load at most one element of this tile
	one_enable_a: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown({en_sb, en_cb0, en_cb1, en_clb})
			&& $onehot0({en_sb, en_cb0, en_cb1, en_clb})
	) else $error("tile %0d: config enables unknown or more than one high", TILE_ID);

endmodule

/* rtl/cgra_row.sv */
`timescale 1ns/100ps

module cgra_row (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] config_addr,
	input  logic [31:0] config_data,
	input  logic [7:0]  north_in,
	input  logic [7:0]  south_in,
	input  logic [3:0]  west_in,
	input  logic [3:0]  east_in,
	output logic [7:0]  north_out,
	output logic [7:0]  south_out,
	output logic [3:0]  west_out,
	output logic [3:0]  east_out
);

	// Tracks crossing between the two tiles
	logic [3:0] t0_to_t1;
	logic [3:0] t1_to_t0;

	// Tile 0 holds the low nibbles of north and south
	pe_tile #(
		.TILE_ID(16'd1)
	) tile_0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.in_wire_0  (north_in[3:0]),
		.in_wire_1  (t1_to_t0),
		.in_wire_2  (south_in[3:0]),
		.in_wire_3  (west_in),
		.out_wire_0 (north_out[3:0]),
		.out_wire_1 (t0_to_t1),
		.out_wire_2 (south_out[3:0]),
		.out_wire_3 (west_out)
	);

	pe_tile #(
		.TILE_ID(16'd2)
	) tile_1 (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.in_wire_0  (north_in[7:4]),
		.in_wire_1  (east_in),
		.in_wire_2  (south_in[7:4]),
		.in_wire_3  (t0_to_t1),
		.out_wire_0 (north_out[7:4]),
		.out_wire_1 (east_out),
		.out_wire_2 (south_out[7:4]),
		.out_wire_3 (t1_to_t0)
	);

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 5
) (
	input  logic rst_req,
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset at start, and again on every rising edge of rst_req
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		forever begin
			@(posedge rst_req);
			arst_n = 1'b0;
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			arst_n = 1'b1;
		end
	end

endmodule

/* verification/tb_cgra_row.sv */
`timescale 1ns/100ps

module tb_cgra_row;

	import cgra_pkg::*;

	localparam int CLK_PERIOD_NS = 8;
	localparam int RESET_CYCLES  = 5;
	localparam int N_RESET_VEC   = 24;
	localparam int N_ROUTE_CFG   = 24;
	localparam int N_OP_CFG      = 8;
	localparam int VEC_PER_CFG   = 8;
	// Ten writes of two cycles each per full row configuration
	localparam int CFG_CYCLES    = 20;
	localparam int ISO_CYCLES    = 60;
	localparam int RST_CYCLES    = CFG_CYCLES + 6 + N_RESET_VEC;
	localparam int RUN_CYCLES    = RESET_CYCLES + N_RESET_VEC
		+ (N_ROUTE_CFG + 4 * N_OP_CFG) * (CFG_CYCLES + VEC_PER_CFG)
		+ ISO_CYCLES + RST_CYCLES + 8;
	localparam int TIMEOUT_NS    = RUN_CYCLES * CLK_PERIOD_NS + 2000;

	logic        clk;
	logic        arst_n;
	logic        rst_req;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [7:0]  north_in;
	logic [7:0]  south_in;
	logic [3:0]  west_in;
	logic [3:0]  east_in;
	logic [7:0]  north_out;
	logic [7:0]  south_out;
	logic [3:0]  west_out;
	logic [3:0]  east_out;

	// Mirror of both tiles, index 0 is TILE_ID 1
	logic [1:0][31:0] sb_m;
	logic [1:0][2:0]  cb0_m;
	logic [1:0][2:0]  cb1_m;
	logic [1:0][1:0]  op_m;

	logic [31:0] lfsr;
	logic [23:0] exp_out;
	logic        check_en;
	int          errors;
	int          n_checks;

	tb_clock_gen #(
		.PERIOD_NS   (CLK_PERIOD_NS),
		.RESET_CYCLES(RESET_CYCLES)
	) clock_gen (
		.rst_req(rst_req),
		.clk    (clk),
		.arst_n (arst_n)
	);

	cgra_row DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.north_in   (north_in),
		.south_in   (south_in),
		.west_in    (west_in),
		.east_in    (east_in),
		.north_out  (north_out),
		.south_out  (south_out),
		.west_out   (west_out),
		.east_out   (east_out)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	// One tile, returns {side 3, side 2, side 1, side 0}
	function automatic logic [15:0] tile_eval(input logic [31:0] sb, input logic [2:0] c0,
			input logic [2:0] c1, input logic [1:0] op, input logic [3:0] i0,
			input logic [3:0] i1, input logic [3:0] i2, input logic [3:0] i3);
		logic [3:0][3:0] in_s;
		logic [3:0][3:0] out_s;
		logic [7:0]      trk0;
		logic [7:0]      trk1;
		logic            a;
		logic            b;
		logic            pe;
		int              v;
		in_s = {i3, i2, i1, i0};
		out_s = '0;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				v = sb[(s * 4 + t) * 2 +: 2];
				if (v != 3)
					out_s[s][t] = in_s[(s + 1 + v) % 4][t];
			end
		end
		trk0 = {out_s[0], in_s[0]};
		trk1 = {out_s[1], in_s[1]};
		a = trk0[c0];
		b = trk1[c1];
		case (op)
			CLB_AND: pe = a & b;
			CLB_OR:  pe = a | b;
			CLB_XOR: pe = a ^ b;
			default: pe = ~(a & b);
		endcase
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				if (sb[(s * 4 + t) * 2 +: 2] == 2'd3)
					out_s[s][t] = pe;
			end
		end
		return {out_s[3], out_s[2], out_s[1], out_s[0]};
	endfunction

	// Returns {north_out, south_out, west_out, east_out}
	function automatic logic [23:0] row_model(input logic [1:0][31:0] sb,
			input logic [1:0][2:0] c0, input logic [1:0][2:0] c1, input logic [1:0][1:0] op,
			input logic [7:0] n, input logic [7:0] s, input logic [3:0] w, input logic [3:0] e);
		logic [15:0] t0;
		logic [15:0] t1;
		// Tile 1 west side never depends on its own west input
		t1 = tile_eval(sb[1], c0[1], c1[1], op[1], n[7:4], e, s[7:4], 4'd0);
		t0 = tile_eval(sb[0], c0[0], c1[0], op[0], n[3:0], t1[15:12], s[3:0], w);
		t1 = tile_eval(sb[1], c0[1], c1[1], op[1], n[7:4], e, s[7:4], t0[7:4]);
		return {t1[3:0], t0[3:0], t1[11:8], t0[11:8], t0[15:12], t1[7:4]};
	endfunction

	task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
		int ti;
		@(negedge clk);
		check_en = 1'b0;
		config_addr = addr;
		config_data = data;
		ti = -1;
		if (addr[15:0] == 16'd1)
			ti = 0;
		else if (addr[15:0] == 16'd2)
			ti = 1;
		if (ti >= 0) begin
			case (addr[31:16])
				CFG_SB:  sb_m[ti] = data;
				CFG_CB0: cb0_m[ti] = data[2:0];
				CFG_CB1: cb1_m[ti] = data[2:0];
				CFG_CLB: op_m[ti] = data[1:0];
				default: ;
			endcase
		end
		@(negedge clk);
		config_addr = '0;
		config_data = '0;
	endtask

	task automatic apply_vector();
		logic [31:0] r;
		@(negedge clk);
		rand_bits(24, r);
		north_in = r[7:0];
		south_in = r[15:8];
		west_in = r[19:16];
		east_in = r[23:20];
		exp_out = row_model(sb_m, cb0_m, cb1_m, op_m, north_in, south_in, west_in, east_in);
		check_en = 1'b1;
	endtask

	// Switch boxes are cleared first so no partial setup closes a loop
	task automatic load_random_config(input logic force_op, input logic [1:0] op_val);
		logic [1:0][31:0] sb_new;
		logic [1:0][2:0]  c0_new;
		logic [1:0][2:0]  c1_new;
		logic [1:0][1:0]  op_new;
		logic [31:0]      r;
		for (int ti = 0; ti < 2; ti++) begin
			rand_bits(32, r);
			sb_new[ti] = r;
			rand_bits(3, r);
			c0_new[ti] = r[2:0];
			rand_bits(3, r);
			c1_new[ti] = r[2:0];
			rand_bits(2, r);
			op_new[ti] = force_op ? op_val : r[1:0];
			if (force_op) begin
				rand_bits(2, r);
				sb_new[ti][(8 + r[1:0]) * 2 +: 2] = SB_SEL_PE;
			end
			// Connect box on own outputs: logic block output only goes south
			if (c0_new[ti][2] || c1_new[ti][2]) begin
				for (int i = 0; i < 16; i++) begin
					if (i / 4 != 2 && sb_new[ti][i * 2 +: 2] == SB_SEL_PE)
						sb_new[ti][i * 2 +: 2] = 2'd0;
				end
			end
		end
		cfg_write({CFG_SB, 16'd1}, 32'd0);
		cfg_write({CFG_SB, 16'd2}, 32'd0);
		for (int ti = 0; ti < 2; ti++) begin
			cfg_write({CFG_CB0, 16'(ti + 1)}, {29'd0, c0_new[ti]});
			cfg_write({CFG_CB1, 16'(ti + 1)}, {29'd0, c1_new[ti]});
			cfg_write({CFG_CLB, 16'(ti + 1)}, {30'd0, op_new[ti]});
		end
		for (int ti = 0; ti < 2; ti++)
			cfg_write({CFG_SB, 16'(ti + 1)}, sb_new[ti]);
	endtask

	task automatic isolation_test();
		logic [31:0] r;
		load_random_config(1'b0, 2'd0);
		repeat (4) apply_vector();
		// Tile 2 switch box without logic block selects, then the rest of tile 2
		rand_bits(32, r);
		for (int i = 0; i < 16; i++) begin
			if (r[i * 2 +: 2] == 2'd3)
				r[i * 2 +: 2] = 2'd2;
		end
		cfg_write({CFG_SB, 16'd2}, r);
		rand_bits(32, r);
		cfg_write({CFG_CB0, 16'd2}, r);
		rand_bits(32, r);
		cfg_write({CFG_CB1, 16'd2}, r);
		rand_bits(32, r);
		cfg_write({CFG_CLB, 16'd2}, r);
		repeat (4) apply_vector();
		// Unused element codes
		rand_bits(32, r);
		cfg_write({16'd3, 16'd1}, r & 32'h5555_5555);
		cfg_write({16'd8, 16'd1}, r & 32'h5555_5555);
		cfg_write({16'd0, 16'd1}, r & 32'h5555_5555);
		cfg_write({16'hffff, 16'd1}, r & 32'h5555_5555);
		repeat (4) apply_vector();
		// Unknown tile identifiers
		rand_bits(32, r);
		cfg_write({CFG_SB, 16'd0}, r & 32'h5555_5555);
		cfg_write({CFG_SB, 16'd3}, r & 32'h5555_5555);
		cfg_write({CFG_CB0, 16'hffff}, r & 32'h5555_5555);
		cfg_write({CFG_CLB, 16'h0101}, r & 32'h5555_5555);
		repeat (4) apply_vector();
	endtask

	task automatic reset_test();
		load_random_config(1'b0, 2'd0);
		repeat (4) apply_vector();
		@(negedge clk);
		check_en = 1'b0;
		rst_req = 1'b1;
		sb_m = '0;
		cb0_m = '0;
		cb1_m = '0;
		op_m = '0;
		@(negedge clk);
		rst_req = 1'b0;
		repeat (N_RESET_VEC) apply_vector();
		if (arst_n !== 1'b1) begin
			errors++;
			$display("Reset was never released after the mid-run reset request");
		end
	endtask

	always @(posedge clk) begin
		if (check_en) begin
			n_checks++;
			if (north_out !== exp_out[23:16]) begin
				errors++;
				$display("ERR %0t north_out expected %h got %h", $time, exp_out[23:16], north_out);
			end
			if (south_out !== exp_out[15:8]) begin
				errors++;
				$display("ERR %0t south_out expected %h got %h", $time, exp_out[15:8], south_out);
			end
			if (west_out !== exp_out[7:4]) begin
				errors++;
				$display("ERR %0t west_out expected %h got %h", $time, exp_out[7:4], west_out);
			end
			if (east_out !== exp_out[3:0]) begin
				errors++;
				$display("ERR %0t east_out expected %h got %h", $time, exp_out[3:0], east_out);
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		rst_req = 1'b0;
		config_addr = '0;
		config_data = '0;
		north_in = '0;
		south_in = '0;
		west_in = '0;
		east_in = '0;
		check_en = 1'b0;
		sb_m = '0;
		cb0_m = '0;
		cb1_m = '0;
		op_m = '0;
		lfsr = 32'h997b_3a44;
		errors = 0;
		n_checks = 0;
		wait (arst_n === 1'b1);

		// Reset routing, no writes yet
		repeat (N_RESET_VEC) apply_vector();

		repeat (N_ROUTE_CFG) begin
			load_random_config(1'b0, 2'd0);
			repeat (VEC_PER_CFG) apply_vector();
		end

		for (int op = 0; op < 4; op++) begin
			repeat (N_OP_CFG) begin
				load_random_config(1'b1, 2'(op));
				repeat (VEC_PER_CFG) apply_vector();
			end
		end

		isolation_test();
		reset_test();

		@(negedge clk);
		check_en = 1'b0;
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* sources.f */
rtl/cgra_pkg.sv
rtl/switch_box.sv
rtl/connect_box.sv
rtl/clb.sv
rtl/pe_tile.sv
rtl/cgra_row.sv
verification/tb_clock_gen.sv
verification/tb_cgra_row.sv
